/* rtl/apbRegBank.sv */
module apbRegBank (
	input  logic                  clk,
	input  logic                  rst_n,
	input  ttlBridgePkg::apbAddrT paddr,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  ttlBridgePkg::mstDataT pwdata,
	output ttlBridgePkg::mstDataT prdata,
	output logic                  irq,
	ctrlRegIf.bank                regs
);
	import ttlBridgePkg::*;

	logic [CtrlWidth-1:0] ctrlReg;
	mstAddrT baseReg;
	ttlAddrT ovrAddrReg;
	ttlDataT ovrDataReg;
	intrKindT pendReg;
	logic errReg;
	logic wrEn;
	intrKindT pendClr;
	logic errClr;

	// APB2 access phase, no wait states
	assign wrEn = psel && penable && pwrite;

	// Write-1-to-clear strobes
	assign pendClr = (wrEn && paddr == RegIntr) ? pwdata[IntrKinds-1:0] : '0;
	assign errClr = wrEn && (paddr == RegStatus) && pwdata[StatusErrBit];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrlReg <= '0;
			baseReg <= '0;
			ovrAddrReg <= '0;
			ovrDataReg <= '0;
			pendReg <= '0;
			errReg <= 1'b0;
		end else begin
			if (wrEn) begin
				case (paddr)
					RegCtrl: ctrlReg <= pwdata[CtrlWidth-1:0];
					RegBase: baseReg <= pwdata;
					RegOvrAddr: ovrAddrReg <= pwdata[TtlAddrWidth-1:0];
					RegOvrData: ovrDataReg <= pwdata[TtlDataWidth-1:0];
					default: ;
				endcase
			end
			// A new event wins over a clear in the same cycle
			pendReg <= (pendReg & ~pendClr) | regs.intrSet;
			errReg <= (errReg & ~errClr) | regs.errSet;
		end
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			RegCtrl: prdata[CtrlWidth-1:0] = ctrlReg;
			RegStatus: begin
				prdata[StateWidth-1:0] = regs.state;
				prdata[StatusBusyBit] = regs.busy;
				prdata[StatusErrBit] = errReg;
			end
			RegIntr: prdata[IntrKinds-1:0] = pendReg;
			RegBase: prdata = baseReg;
			RegOvrAddr: prdata[TtlAddrWidth-1:0] = ovrAddrReg;
			RegOvrData: prdata[TtlDataWidth-1:0] = ovrDataReg;
			RegLast: prdata[TtlAddrWidth+TtlDataWidth-1:0] = {regs.lastAddr, regs.lastData};
			default: prdata = '0;
		endcase
	end

	assign irq = |pendReg;

	assign regs.enable = ctrlReg[CtrlEnableBit];
	assign regs.intrArm = ctrlReg[CtrlWidth-1:1];
	assign regs.baseAddr = baseReg;
	assign regs.ovrAddr = ovrAddrReg;
	assign regs.ovrData = ovrDataReg;
	assign regs.intrPending = pendReg;

endmodule

/* rtl/ctrlRegIf.sv */
interface ctrlRegIf;
	import ttlBridgePkg::*;

	// Configuration from the register bank
	logic enable;
	intrKindT intrArm;
	mstAddrT baseAddr;
	ttlAddrT ovrAddr;
	ttlDataT ovrData;
	intrKindT intrPending;

	// Events and status from the FSM
	intrKindT intrSet;
	logic errSet;
	bridgeStateT state;
	logic busy;
	ttlAddrT lastAddr;
	ttlDataT lastData;

	modport bank (
		output enable, intrArm, baseAddr, ovrAddr, ovrData, intrPending,
		input intrSet, errSet, state, busy, lastAddr, lastData
	);

	modport fsm (
		input enable, intrArm, baseAddr, ovrAddr, ovrData, intrPending,
		output intrSet, errSet, state, busy, lastAddr, lastData
	);

endinterface

/* rtl/mstCmdIf.sv */
interface mstCmdIf;
	import ttlBridgePkg::*;

	// Request side, held until cmdAck
	logic rdReq;
	logic wrReq;
	mstAddrT addr;
	mstDataT wrData;

	// Response side, error and rdData qualified by cmplt
	logic cmdAck;
	logic cmplt;
	logic error;
	mstDataT rdData;

	modport master (
		output rdReq, wrReq, addr, wrData,
		input cmdAck, cmplt, error, rdData
	);

	modport port (
		input rdReq, wrReq, addr, wrData,
		output cmdAck, cmplt, error, rdData
	);

endinterface

/* rtl/ttlBridgeFsm.sv */
module ttlBridgeFsm (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ceSync,
	input  logic                  oeSync,
	input  logic                  weSync,
	input  ttlBridgePkg::ttlAddrT addrCap,
	input  ttlBridgePkg::ttlDataT dataCap,
	output ttlBridgePkg::ttlDataT dataOut,
	output logic                  dataOe,
	ctrlRegIf.fsm                 regs,
	mstCmdIf.master               mst
);
	import ttlBridgePkg::*;

	bridgeStateT state;
	bridgeStateT stateNext;
	ttlAddrT accAddr;
	ttlDataT accData;
	logic isWrite;
	logic rdValid;
	logic accessSeen;
	logic intrDone;
	intrKindT waitMask;
	intrKindT intrEnter;

	assign accessSeen = ceSync && (weSync || oeSync);

	// Pending bit owned by the current intercept state
	always_comb begin
		waitMask = '0;
		case (state)
			AddrIntr: waitMask[IntrAddr] = 1'b1;
			ReadIntr: waitMask[IntrRead] = 1'b1;
			WriteIntr: waitMask[IntrWrite] = 1'b1;
			default: waitMask = '0;
		endcase
	end

	// The set pulse is still on its way to the bank in the first intercept cycle
	assign intrDone = (regs.intrSet == '0) && ((regs.intrPending & waitMask) == '0);

	always_comb begin
		stateNext = state;
		case (state)
			Disabled: begin
				if (regs.enable)
					stateNext = Idle;
			end
			Idle: begin
				if (!regs.enable)
					stateNext = Disabled;
				else if (accessSeen) begin
					if (regs.intrArm[IntrAddr])
						stateNext = AddrIntr;
					else if (weSync && regs.intrArm[IntrWrite])
						stateNext = WriteIntr;
					else
						stateNext = MstReq;
				end
			end
			AddrIntr: begin
				if (intrDone)
					stateNext = (isWrite && regs.intrArm[IntrWrite]) ? WriteIntr : MstReq;
			end
			WriteIntr: begin
				if (intrDone)
					stateNext = MstReq;
			end
			MstReq: stateNext = MstWait;
			MstWait: begin
				// Failed reads skip the read intercept
				if (mst.cmplt)
					stateNext = (!isWrite && !mst.error && regs.intrArm[IntrRead]) ?
						ReadIntr : Respond;
			end
			ReadIntr: begin
				if (intrDone)
					stateNext = Respond;
			end
			Respond: stateNext = Release;
			Release: begin
				if (!ceSync && !oeSync && !weSync)
					stateNext = Idle;
			end
			default: stateNext = Disabled;
		endcase
	end

	// One set pulse on entry to an intercept state
	always_comb begin
		intrEnter = '0;
		if (stateNext != state) begin
			intrEnter[IntrAddr] = (stateNext == AddrIntr);
			intrEnter[IntrRead] = (stateNext == ReadIntr);
			intrEnter[IntrWrite] = (stateNext == WriteIntr);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= Disabled;
			mst.rdReq <= 1'b0;
			mst.wrReq <= 1'b0;
			regs.intrSet <= '0;
			regs.errSet <= 1'b0;
			regs.lastAddr <= '0;
			regs.lastData <= '0;
			rdValid <= 1'b0;
		end else begin
			state <= stateNext;
			regs.intrSet <= intrEnter;
			regs.errSet <= (state == MstWait) && mst.cmplt && mst.error;
			// Request held until acknowledged
			if (state == MstReq) begin
				mst.rdReq <= !isWrite;
				mst.wrReq <= isWrite;
			end else if (mst.cmdAck) begin
				mst.rdReq <= 1'b0;
				mst.wrReq <= 1'b0;
			end
			if (state == Respond) begin
				regs.lastAddr <= accAddr;
				regs.lastData <= accData;
				rdValid <= !isWrite;
			end else if (!oeSync || !ceSync) begin
				rdValid <= 1'b0;
			end
		end
	end

	// Access payload
	always_ff @(posedge clk) begin
		case (state)
			Idle: begin
				if (accessSeen) begin
					accAddr <= addrCap;
					isWrite <= weSync;
					if (weSync)
						accData <= dataCap;
				end
			end
			AddrIntr: begin
				if (intrDone)
					accAddr <= regs.ovrAddr;
			end
			WriteIntr: begin
				if (intrDone)
					accData <= regs.ovrData;
			end
			MstReq: begin
				mst.addr <= regs.baseAddr + mstAddrT'(accAddr);
				mst.wrData <= mstDataT'(accData);
			end
			MstWait: begin
				if (mst.cmplt && !isWrite)
					accData <= mst.error ? ErrReadByte : mst.rdData[TtlDataWidth-1:0];
			end
			ReadIntr: begin
				if (intrDone)
					accData <= regs.ovrData;
			end
			Respond: dataOut <= accData;
			default: ;
		endcase
	end

	// Drive only while the device still reads
	assign dataOe = rdValid && ceSync && oeSync;

	assign regs.state = state;
	assign regs.busy = (state != Disabled) && (state != Idle);

endmodule

/* rtl/ttlBridgePkg.sv */
package ttlBridgePkg;

	// Bus widths
	localparam int TtlAddrWidth = 16;
	localparam int TtlDataWidth = 8;
	localparam int MstAddrWidth = 32;
	localparam int MstDataWidth = 32;
	localparam int ApbAddrWidth = 5;
	localparam int StateWidth = 5;
	localparam int CtrlWidth = 4;
	localparam int IntrKinds = 3;

	typedef logic [TtlAddrWidth-1:0] ttlAddrT;
	typedef logic [TtlDataWidth-1:0] ttlDataT;
	typedef logic [MstAddrWidth-1:0] mstAddrT;
	typedef logic [MstDataWidth-1:0] mstDataT;
	typedef logic [ApbAddrWidth-1:0] apbAddrT;
	typedef logic [IntrKinds-1:0] intrKindT;

	// APB register map
	localparam apbAddrT RegCtrl = 5'h00;
	localparam apbAddrT RegStatus = 5'h04;
	localparam apbAddrT RegIntr = 5'h08;
	localparam apbAddrT RegBase = 5'h0C;
	localparam apbAddrT RegOvrAddr = 5'h10;
	localparam apbAddrT RegOvrData = 5'h14;
	localparam apbAddrT RegLast = 5'h18;

	// Intercept bit positions, control arms them one bit higher
	localparam int CtrlEnableBit = 0;
	localparam int IntrAddr = 0;
	localparam int IntrRead = 1;
	localparam int IntrWrite = 2;
	localparam int StatusBusyBit = 8;
	localparam int StatusErrBit = 9;

	// Byte returned to the device after a failed master read
	localparam ttlDataT ErrReadByte = 8'hFF;

	typedef enum logic [StateWidth-1:0] {
		Disabled, Idle, AddrIntr, MstReq, MstWait, ReadIntr, WriteIntr, Respond, Release
	} bridgeStateT;

endpackage

/* rtl/ttlBridgeTop.sv */
module ttlBridgeTop (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ttlCeN,
	input  logic                  ttlOeN,
	input  logic                  ttlWeN,
	input  ttlBridgePkg::ttlAddrT ttlAddr,
	input  ttlBridgePkg::ttlDataT ttlDataIn,
	output ttlBridgePkg::ttlDataT ttlDataOut,
	output logic                  ttlDataOe,
	input  ttlBridgePkg::apbAddrT paddr,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  ttlBridgePkg::mstDataT pwdata,
	output ttlBridgePkg::mstDataT prdata,
	output logic                  irq,
	output logic                  mstRdReq,
	output logic                  mstWrReq,
	output ttlBridgePkg::mstAddrT mstAddr,
	output ttlBridgePkg::mstDataT mstWrData,
	input  logic                  mstCmdAck,
	input  logic                  mstCmplt,
	input  logic                  mstError,
	input  ttlBridgePkg::mstDataT mstRdData
);

	logic ceSync;
	logic oeSync;
	logic weSync;
	ttlBridgePkg::ttlAddrT addrCap;
	ttlBridgePkg::ttlDataT dataCap;

	mstCmdIf mstBus ();
	ctrlRegIf ctrlBus ();

	ttlBusSync i_ttlBusSync (
		.clk(clk), .rst_n(rst_n),
		.ceN(ttlCeN), .oeN(ttlOeN), .weN(ttlWeN),
		.addr(ttlAddr), .dataIn(ttlDataIn),
		.ceSync(ceSync), .oeSync(oeSync), .weSync(weSync),
		.addrCap(addrCap), .dataCap(dataCap)
	);

	apbRegBank i_apbRegBank (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .irq(irq),
		.regs(ctrlBus.bank)
	);

	ttlBridgeFsm i_ttlBridgeFsm (
		.clk(clk), .rst_n(rst_n),
		.ceSync(ceSync), .oeSync(oeSync), .weSync(weSync),
		.addrCap(addrCap), .dataCap(dataCap),
		.dataOut(ttlDataOut), .dataOe(ttlDataOe),
		.regs(ctrlBus.fsm), .mst(mstBus.master)
	);

	// Master command channel out to the pins
	assign mstRdReq = mstBus.rdReq;
	assign mstWrReq = mstBus.wrReq;
	assign mstAddr = mstBus.addr;
	assign mstWrData = mstBus.wrData;
	assign mstBus.cmdAck = mstCmdAck;
	assign mstBus.cmplt = mstCmplt;
	assign mstBus.error = mstError;
	assign mstBus.rdData = mstRdData;

endmodule

/* rtl/ttlBusSync.sv */
module ttlBusSync (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ceN,
	input  logic                  oeN,
	input  logic                  weN,
	input  ttlBridgePkg::ttlAddrT addr,
	input  ttlBridgePkg::ttlDataT dataIn,
	output logic                  ceSync,
	output logic                  oeSync,
	output logic                  weSync,
	output ttlBridgePkg::ttlAddrT addrCap,
	output ttlBridgePkg::ttlDataT dataCap
);
	import ttlBridgePkg::*;

	// Strobes packed as {ce, oe, we}, still active low
	logic [2:0] strbMeta;
	logic [2:0] strbSync;
	ttlAddrT addrMeta;
	ttlDataT dataMeta;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			strbMeta <= 3'b111;
			strbSync <= 3'b111;
		end else begin
			strbMeta <= {ceN, oeN, weN};
			strbSync <= strbMeta;
		end
	end

	// Same two-stage delay so address and data line up with the strobes
	always_ff @(posedge clk) begin
		addrMeta <= addr;
		dataMeta <= dataIn;
		addrCap <= addrMeta;
		dataCap <= dataMeta;
	end

	assign ceSync = ~strbSync[2];
	assign oeSync = ~strbSync[1];
	assign weSync = ~strbSync[0];

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module ttlBridgeTb -f ttlBridgeTop.f

./obj_dir/VttlBridgeTb | tee sim.log

if grep -qx "Testbench passed" sim.log; then
	echo "Simulation result: PASS"
else
	echo "Simulation result: FAIL"
	exit 1
fi

/* ttlBridgeTop.f */
rtl/ttlBridgePkg.sv
rtl/mstCmdIf.sv
rtl/ctrlRegIf.sv
rtl/ttlBusSync.sv
rtl/apbRegBank.sv
rtl/ttlBridgeFsm.sv
rtl/ttlBridgeTop.sv
verif/ttlBridge_assertions.sv
verif/ttlBridgeTb.sv

/* verif/ttlBridgeTb.sv */
module ttlBridgeTb;
	import ttlBridgePkg::*;

	logic clk;
	logic rst_n;
	logic ttlCeN;
	logic ttlOeN;
	logic ttlWeN;
	ttlAddrT ttlAddr;
	ttlDataT ttlDataIn;
	ttlDataT ttlDataOut;
	logic ttlDataOe;
	apbAddrT paddr;
	logic psel;
	logic penable;
	logic pwrite;
	mstDataT pwdata;
	mstDataT prdata;
	logic irq;
	logic mstRdReq;
	logic mstWrReq;
	mstAddrT mstAddr;
	mstDataT mstWrData;
	logic mstCmdAck;
	logic mstCmplt;
	logic mstError;
	mstDataT mstRdData;

	string traceLines[$];
	int cycleCount;
	int cycleLimit;
	int cmpltCount;
	int startCount;

	// Master memory, error addresses and the log of finished commands
	mstDataT mem [mstAddrT];
	bit errAddr [mstAddrT];
	bit cmdKindLog[$];
	mstAddrT cmdAddrLog[$];
	mstDataT cmdDataLog[$];

	ttlBridgeTop i_ttlBridgeTop (
		.clk(clk), .rst_n(rst_n),
		.ttlCeN(ttlCeN), .ttlOeN(ttlOeN), .ttlWeN(ttlWeN),
		.ttlAddr(ttlAddr), .ttlDataIn(ttlDataIn),
		.ttlDataOut(ttlDataOut), .ttlDataOe(ttlDataOe),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .irq(irq),
		.mstRdReq(mstRdReq), .mstWrReq(mstWrReq), .mstAddr(mstAddr),
		.mstWrData(mstWrData), .mstCmdAck(mstCmdAck), .mstCmplt(mstCmplt),
		.mstError(mstError), .mstRdData(mstRdData)
	);

	always #50 clk = ~clk;

	task automatic stopRun();
		$display("Testbench failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Error: the run hung and reached the limit of %0d cycles", cycleLimit);
			stopRun();
		end
	end

	task automatic compareMstAddr(input mstAddrT got, input mstAddrT exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
			stopRun();
		end
	endtask

	task automatic compareTtlData(input ttlDataT got, input ttlDataT exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
			stopRun();
		end
	endtask

	task automatic compareReg(input mstDataT got, input mstDataT exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
			stopRun();
		end
	endtask

	task automatic compareFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %b, expected %b", $time, what, got, exp);
			stopRun();
		end
	endtask

	// Unwritten memory words depend on every address bit
	function automatic mstDataT memFill(input mstAddrT addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
	endfunction

	task automatic apbWrite(input apbAddrT addr, input mstDataT data);
		@(posedge clk);
		paddr <= addr;
		pwdata <= data;
		pwrite <= 1'b1;
		psel <= 1'b1;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apbRead(input apbAddrT addr, output mstDataT data);
		@(posedge clk);
		paddr <= addr;
		pwrite <= 1'b0;
		psel <= 1'b1;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic ttlStart(input bit isWrite, input ttlAddrT addr, input ttlDataT data);
		@(posedge clk);
		ttlAddr <= addr;
		ttlDataIn <= data;
		ttlCeN <= 1'b0;
		ttlWeN <= !isWrite;
		ttlOeN <= isWrite;
		startCount = cmpltCount;
	endtask

	// Strobes off with time for the synchronizer and the Release state
	task automatic ttlRelease();
		@(posedge clk);
		ttlCeN <= 1'b1;
		ttlOeN <= 1'b1;
		ttlWeN <= 1'b1;
		repeat (5) @(posedge clk);
	endtask

	task automatic checkCommand(input mstDataT kind, input mstAddrT addr, input mstDataT data);
		do @(negedge clk); while (cmdAddrLog.size() == 0);
		compareReg(mstDataT'(cmdKindLog.pop_front()), kind, "master command kind");
		compareMstAddr(cmdAddrLog.pop_front(), addr, "master address");
		if (kind == 1)
			compareReg(cmdDataLog.pop_front(), data, "master write data");
		else
			void'(cmdDataLog.pop_front());
	endtask

	task automatic serviceIntercept(input mstDataT pend, input mstDataT ovrReg,
			input mstDataT ovrVal);
		mstDataT got;
		do @(negedge clk); while (!irq);
		apbRead(RegIntr, got);
		compareReg(got, pend, "pending intercepts");
		apbWrite(apbAddrT'(ovrReg), ovrVal);
		apbWrite(RegIntr, pend);
		@(negedge clk);
		compareFlag(irq, 1'b0, "irq after clear");
	endtask

	task automatic runOp(input string line);
		string op;
		byte opc;
		mstDataT f1;
		mstDataT f2;
		mstDataT f3;
		mstDataT got;
		f1 = '0;
		f2 = '0;
		f3 = '0;
		void'($sscanf(line, "%s %h %h %h", op, f1, f2, f3));
		opc = op[0];
		case (opc)
			"A": apbWrite(apbAddrT'(f1), f2);
			"R": begin
				apbRead(apbAddrT'(f1), got);
				compareReg(got, f2, $sformatf("register %h", f1[4:0]));
			end
			"T": ttlStart(1'b1, ttlAddrT'(f1), ttlDataT'(f2));
			"O": ttlStart(1'b0, ttlAddrT'(f1), '0);
			"E": begin
				do @(negedge clk); while (cmpltCount == startCount);
				ttlRelease();
			end
			"F": begin
				do @(negedge clk); while (!ttlDataOe);
				compareTtlData(ttlDataOut, ttlDataT'(f1), "TTL read byte");
				ttlRelease();
				@(negedge clk);
				compareFlag(ttlDataOe, 1'b0, "TTL data enable after release");
			end
			"N": begin
				repeat (f1) @(posedge clk);
				ttlRelease();
				if (cmpltCount != startCount) begin
					$display("Error: a master command ran while the bridge was disabled");
					stopRun();
				end
			end
			"M": checkCommand(f1, f2, f3);
			"I": serviceIntercept(f1, f2, f3);
			"P": mem[f1] = f2;
			"X": errAddr[f1] = 1'b1;
			default: begin
				$display("Error: unknown trace opcode in line: %s", line);
				stopRun();
			end
		endcase
	endtask

	task automatic loadTrace();
		int fd;
		int n;
		string line;
		fd = $fopen("verif/ttlBridgeTrace.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open the trace file verif/ttlBridgeTrace.txt");
			stopRun();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// Comment and blank lines do not start with a capital letter
				if (n > 0 && line[0] >= "A" && line[0] <= "Z")
					traceLines.push_back(line);
			end
			$fclose(fd);
		end
	endtask

	// Memory model with random ack and completion delays
	initial begin : memoryModel
		mstAddrT reqAddr;
		mstDataT reqData;
		mstDataT rspData;
		logic reqWr;
		logic reqErr;
		int ackWait;
		int doneWait;
		void'($urandom(54984));
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk);
			if (mstRdReq || mstWrReq) begin
				reqWr = mstWrReq;
				reqAddr = mstAddr;
				reqData = mstWrData;
				reqErr = errAddr.exists(reqAddr);
				rspData = '0;
				if (reqWr && !reqErr)
					mem[reqAddr] = reqData;
				else if (!reqWr)
					rspData = mem.exists(reqAddr) ? mem[reqAddr] : memFill(reqAddr);
				ackWait = $urandom_range(5, 0);
				doneWait = $urandom_range(5, 0);
				for (int cyc = 0; cyc <= ackWait + doneWait; cyc++) begin
					@(posedge clk);
					mstCmdAck <= (cyc == ackWait);
					if (cyc == ackWait + doneWait) begin
						mstCmplt <= 1'b1;
						mstError <= reqErr;
						mstRdData <= rspData;
						cmdKindLog.push_back(reqWr);
						cmdAddrLog.push_back(reqAddr);
						cmdDataLog.push_back(reqData);
						cmpltCount = cmpltCount + 1;
					end
				end
				@(posedge clk);
				mstCmdAck <= 1'b0;
				mstCmplt <= 1'b0;
				mstError <= 1'b0;
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		ttlCeN = 1'b1;
		ttlOeN = 1'b1;
		ttlWeN = 1'b1;
		ttlAddr = '0;
		ttlDataIn = '0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		mstCmdAck = 1'b0;
		mstCmplt = 1'b0;
		mstError = 1'b0;
		mstRdData = '0;
		cycleCount = 0;
		cmpltCount = 0;
		startCount = 0;
		cycleLimit = 1000;
		loadTrace();
		cycleLimit = 300 * traceLines.size() + 20;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		compareFlag(irq, 1'b0, "irq after reset");
		compareFlag(ttlDataOe, 1'b0, "TTL data enable after reset");
		compareFlag(mstRdReq, 1'b0, "master read request after reset");
		compareFlag(mstWrReq, 1'b0, "master write request after reset");
		foreach (traceLines[i])
			runOp(traceLines[i]);
		if (cmdAddrLog.size() != 0) begin
			$display("Error: %0d master commands were not expected by the trace",
				cmdAddrLog.size());
			stopRun();
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

/* verif/ttlBridgeTrace.txt */
# Columns: opcode then up to three hex fields
# A reg data | R reg expect | T addr byte | O addr | E | F byte | N cycles
# M kind(1=write) addr data | I pending ovrReg value | P addr word | X addr
R 00 00000000
R 04 00000000
R 08 00000000
R 0C 00000000
R 10 00000000
R 14 00000000
R 18 00000000
T 0010 55
N 14
A 0C 00010000
A 00 00000001
R 04 00000001
T 0020 A5
E
M 1 00010020 000000A5
R 18 000020A5
P 00010040 12345678
O 0040
F 78
M 0 00010040 0
R 18 00004078
A 00 00000003
T 0030 11
I 1 10 0044
E
M 1 00010044 00000011
R 18 00004411
A 00 00000005
P 00010050 000000C3
O 0050
I 2 14 5A
F 5A
M 0 00010050 0
A 00 00000009
T 0060 22
I 4 14 77
E
M 1 00010060 00000077
R 18 00006077
A 00 00000001
X 00010070
O 0070
F FF
M 0 00010070 0
R 04 00000201
A 04 00000200
R 04 00000001
R 18 000070FF
R 1C 00000000

/* verif/ttlBridge_assertions.sv */
module ttlBridge_assertions (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    rdReq,
	input logic                    wrReq,
	input ttlBridgePkg::mstAddrT   addr,
	input ttlBridgePkg::mstDataT   wrData,
	input logic                    cmdAck,
	input logic                    dataOe,
	input logic                    weSync,
	input ttlBridgePkg::intrKindT  intrSet
);
	import ttlBridgePkg::*;

	// Unacknowledged request keeps its command and payload
	assert property (@(posedge clk) disable iff (!rst_n)
		((rdReq || wrReq) && !cmdAck) |=>
			($stable(rdReq) && $stable(wrReq) && $stable(addr) && $stable(wrData)))
		else $error("master request changed before cmdAck");

	// Request drops in the cycle after cmdAck
	assert property (@(posedge clk) disable iff (!rst_n)
		((rdReq || wrReq) && cmdAck) |=> (!rdReq && !wrReq))
		else $error("master request held after cmdAck");

	assert property (@(posedge clk) disable iff (!rst_n) !(rdReq && wrReq))
		else $error("read and write requested together");

	// Never drive the data pins against a device write
	assert property (@(posedge clk) disable iff (!rst_n) !(dataOe && weSync))
		else $error("data output enabled during a write strobe");

	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(intrSet))
		else $error("more than one intercept raised at once");

endmodule

bind ttlBridgeFsm ttlBridge_assertions i_ttlBridgeAssertions (
	.clk(clk),
	.rst_n(rst_n),
	.rdReq(mst.rdReq),
	.wrReq(mst.wrReq),
	.addr(mst.addr),
	.wrData(mst.wrData),
	.cmdAck(mst.cmdAck),
	.dataOe(dataOe),
	.weSync(weSync),
	.intrSet(regs.intrSet)
);
